/* rx_const_pkg.sv */
// datapath widths and payload types shared by the buffer, the FFE and the register block
`default_nettype none

package rx_const_pkg;

    // ADC code and weight widths, both signed
    localparam int CODE_W = 8;
    localparam int WEIGHT_W = 8;

    // number of FFE taps and width of the programmable right shift
    localparam int FFE_LENGTH = 4;
    localparam int SHIFT_W = 4;

    // full-precision product, plus guard bits for the four-tap sum
    localparam int PROD_W = CODE_W + WEIGHT_W;
    localparam int SUM_W = PROD_W + 2;

    // saturated equalizer output
    localparam int RESULT_W = 10;
    localparam int RESULT_MAX = 2 ** (RESULT_W - 1) - 1;
    localparam int RESULT_MIN = -(2 ** (RESULT_W - 1));

    typedef logic signed [CODE_W-1:0] code_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [RESULT_W-1:0] result_t;

    // element 0 is the newest code
    typedef code_t [FFE_LENGTH-1:0] tap_vec_t;

    // weight k multiplies tap k
    typedef weight_t [FFE_LENGTH-1:0] weight_vec_t;

endpackage

`default_nettype wire

/* rx_regs_pkg.sv */
// APB register map, bus structs and the configuration bundle used by the receiver back end
`default_nettype none

package rx_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // register map
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_WEIGHT0 = 8'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_DEC_COUNT = 8'h14;

    // fields of the control register
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_SHIFT_LSB = 4;

    // weight k sits at ADDR_WEIGHT0 + 4k
    localparam int WEIGHT_IDX_W = $clog2(rx_const_pkg::FFE_LENGTH);

    // saturating count of one-decisions
    localparam int DEC_COUNT_W = 16;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                               enable;
        logic [rx_const_pkg::SHIFT_W-1:0]   shift;
        rx_const_pkg::weight_vec_t          weights;
    } rx_cfg_t;

endpackage

`default_nettype wire

/* rx_apb_regs.sv */
// APB slave holding FFE weights, shift and enable, and counting one-decisions for software
`timescale 1ns/1ps
`default_nettype none

module rx_apb_regs (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire rx_regs_pkg::apb_req_t apb_req_i,
    output rx_regs_pkg::apb_rsp_t      apb_rsp_o,
    input  wire logic                  dec_i,
    input  wire logic                  dec_valid_i,
    output rx_regs_pkg::rx_cfg_t       cfg_o
);

    import rx_const_pkg::*;
    import rx_regs_pkg::*;

    logic                    access;
    logic                    wr_en;
    logic                    hit_ctrl;
    logic                    hit_weight;
    logic                    hit_count;
    logic                    bad_access;
    logic [APB_ADDR_W-1:0]   weight_off;
    logic [WEIGHT_IDX_W-1:0] weight_idx;
    logic [DEC_COUNT_W-1:0]  dec_count;

    // access phase of a transfer, no wait states
    assign access = apb_req_i.psel & apb_req_i.penable;

    // address decode
    // an address below the weight window wraps to a large offset and misses
    assign weight_off = apb_req_i.paddr - ADDR_WEIGHT0;
    assign weight_idx = weight_off[2 +: WEIGHT_IDX_W];
    assign hit_ctrl = (apb_req_i.paddr == ADDR_CTRL);
    assign hit_weight = (weight_off[1:0] == 2'b00) && ((weight_off >> 2) < FFE_LENGTH);
    assign hit_count = (apb_req_i.paddr == ADDR_DEC_COUNT);

    // unmapped address, or a count write that is not the clear
    assign bad_access = !(hit_ctrl || hit_weight || hit_count) ||
                        (apb_req_i.pwrite && hit_count && (apb_req_i.pwdata != '0));

    assign wr_en = access & apb_req_i.pwrite & ~bad_access;

    // configuration registers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_o <= '0;
        end else if (wr_en) begin
            if (hit_ctrl) begin
                cfg_o.enable <= apb_req_i.pwdata[CTRL_ENABLE_BIT];
                cfg_o.shift <= apb_req_i.pwdata[CTRL_SHIFT_LSB +: SHIFT_W];
            end
            if (hit_weight) begin
                cfg_o.weights[weight_idx] <= apb_req_i.pwdata[WEIGHT_W-1:0];
            end
        end
    end

    // decision counter
    // a software clear wins over a same-cycle increment
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_count <= '0;
        end else if (wr_en && hit_count) begin
            dec_count <= '0;
        end else if (dec_valid_i && dec_i && !(&dec_count)) begin
            dec_count <= dec_count + 1'b1;
        end
    end

    // read data and error flag, valid in the access phase
    always_comb begin
        apb_rsp_o = '0;
        apb_rsp_o.pready = 1'b1;
        apb_rsp_o.pslverr = access & bad_access;
        if (hit_ctrl) begin
            apb_rsp_o.prdata[CTRL_ENABLE_BIT] = cfg_o.enable;
            apb_rsp_o.prdata[CTRL_SHIFT_LSB +: SHIFT_W] = cfg_o.shift;
        end else if (hit_weight) begin
            apb_rsp_o.prdata[WEIGHT_W-1:0] = cfg_o.weights[weight_idx];
        end else if (hit_count) begin
            apb_rsp_o.prdata[DEC_COUNT_W-1:0] = dec_count;
        end
    end

endmodule

`default_nettype wire

/* rx_sample_buffer.sv */
// code history line that hands the FFE all taps in parallel once per accepted ADC code
`timescale 1ns/1ps
`default_nettype none

module rx_sample_buffer (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire rx_const_pkg::code_t   code_i,
    input  wire logic                  code_valid_i,
    input  wire logic                  enable_i,
    output rx_const_pkg::tap_vec_t     taps_o,
    output logic                       taps_valid_o
);

    import rx_const_pkg::*;

    logic     accept;
    tap_vec_t history;

    // codes arriving while disabled are dropped
    assign accept = code_valid_i & enable_i;

    // newest code enters at element 0, oldest falls off the top
    // history holds through idle cycles and through disable
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            history <= '0;
        end else if (accept) begin
            history <= {history[FFE_LENGTH-2:0], code_i};
        end
    end

    // one-cycle strobe aligned with the updated history
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            taps_valid_o <= 1'b0;
        end else begin
            taps_valid_o <= accept;
        end
    end

    assign taps_o = history;

endmodule

`default_nettype wire

/* rx_ffe.sv */
// three-stage feed-forward equalizer: products, sum, then shift, saturate and slice
`timescale 1ns/1ps
`default_nettype none

module rx_ffe (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,
    input  wire rx_const_pkg::tap_vec_t            taps_i,
    input  wire logic                              taps_valid_i,
    input  wire rx_const_pkg::weight_vec_t         weights_i,
    input  wire logic [rx_const_pkg::SHIFT_W-1:0]  shift_i,
    output rx_const_pkg::result_t                  result_o,
    output logic                                   data_o,
    output logic                                   data_valid_o
);

    import rx_const_pkg::*;

    // stage 1: per-tap products
    logic signed [PROD_W-1:0] prod_q [FFE_LENGTH];
    logic                     s1_valid;

    // stage 2: sum over taps
    logic signed [SUM_W-1:0]  sum_d;
    logic signed [SUM_W-1:0]  sum_q;
    logic                     s2_valid;

    // stage 3 inputs
    logic signed [SUM_W-1:0]  shifted;
    result_t                  result_d;

    // weights are sampled here, together with the taps
    always_ff @(posedge clk_i) begin
        if (taps_valid_i) begin
            for (int k = 0; k < FFE_LENGTH; k++) begin
                prod_q[k] <= weights_i[k] * taps_i[k];
            end
        end
    end

    // two guard bits cover the four-tap worst case
    always_comb begin
        sum_d = '0;
        for (int k = 0; k < FFE_LENGTH; k++) begin
            sum_d = sum_d + prod_q[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            sum_q <= sum_d;
        end
    end

    // arithmetic shift keeps the sign, then clamp to the result range
    assign shifted = sum_q >>> shift_i;

    always_comb begin
        if (shifted > RESULT_MAX) begin
            result_d = result_t'(RESULT_MAX);
        end else if (shifted < RESULT_MIN) begin
            result_d = result_t'(RESULT_MIN);
        end else begin
            result_d = shifted[RESULT_W-1:0];
        end
    end

    // output stage, holds the last decision between valids
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
            data_o <= 1'b0;
        end else if (s2_valid) begin
            result_o <= result_d;
            // slicer, one for strictly positive
            data_o <= (result_d > 0);
        end
    end

    // valid bits move with the data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            s1_valid <= taps_valid_i;
            s2_valid <= s1_valid;
            data_valid_o <= s2_valid;
        end
    end

endmodule

`default_nettype wire

/* rx_top.sv */
// receiver back end top: APB registers, code history and FFE for one lane
`timescale 1ns/1ps
`default_nettype none

module rx_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire rx_const_pkg::code_t    code_i,
    input  wire logic                   code_valid_i,
    input  wire rx_regs_pkg::apb_req_t  apb_req_i,
    output wire rx_regs_pkg::apb_rsp_t  apb_rsp_o,
    output wire rx_const_pkg::result_t  result_o,
    output wire logic                   data_o,
    output wire logic                   data_valid_o
);

    import rx_const_pkg::*;
    import rx_regs_pkg::*;

    // configuration from software
    rx_cfg_t  cfg;

    // history to equalizer
    tap_vec_t taps;
    logic     taps_valid;

    // register block, also counts one-decisions from the slicer
    rx_apb_regs regs0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .dec_i       (data_o),
        .dec_valid_i (data_valid_o),
        .cfg_o       (cfg)
    );

    // accepts codes only while enabled
    rx_sample_buffer buf0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .code_i       (code_i),
        .code_valid_i (code_valid_i),
        .enable_i     (cfg.enable),
        .taps_o       (taps),
        .taps_valid_o (taps_valid)
    );

    // three cycles behind the buffer, four behind the accepted code
    rx_ffe ffe0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .taps_i       (taps),
        .taps_valid_i (taps_valid),
        .weights_i    (cfg.weights),
        .shift_i      (cfg.shift),
        .result_o     (result_o),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// free-running clock for the receiver testbench, instanced once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // low for the first half period, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* tb_rx.sv */
// testbench top for the receiver back end that checks a random APB setup and code stream against a model
`timescale 1ns/1ps
`default_nettype none

module tb_rx;

    import rx_const_pkg::*;
    import rx_regs_pkg::*;

    localparam int DRAIN_LIMIT = 40;

    logic     clk;
    logic     rst_n;
    code_t    code;
    logic     code_valid;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    result_t  result;
    logic     data;
    logic     data_valid;

    // reference model state
    integer   seed;
    logic     m_enable;
    int       m_shift;
    int       m_w [FFE_LENGTH];
    int       m_hist [FFE_LENGTH];
    int       m_ones;
    int       exp_q [$];
    logic [3:0] valid_pipe;
    logic     accepted;
    int       exp_res;
    logic [31:0] rd_data;

    tb_clk_gen #(.PERIOD_NS(100)) clk_gen0 (.clk_o(clk));

    rx_top dut0 (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .code_i       (code),
        .code_valid_i (code_valid),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp),
        .result_o     (result),
        .data_o       (data),
        .data_valid_o (data_valid)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got != exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    // sum of weighted taps, arithmetic shift, clamp to the signed result range
    function automatic int model_result();
        int sum;
        int hi;
        int lo;
        int val;
        sum = 0;
        hi = (1 << (RESULT_W - 1)) - 1;
        lo = -(1 << (RESULT_W - 1));
        for (int k = 0; k < FFE_LENGTH; k++) begin
            sum = sum + m_w[k] * m_hist[k];
        end
        val = sum >>> m_shift;
        if (val > hi) begin
            val = hi;
        end else if (val < lo) begin
            val = lo;
        end
        return val;
    endfunction

    // setup phase, access phase, then back to idle
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic exp_err, output logic [31:0] rdata);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check_value("pready", apb_rsp.pready, 1);
        check_value($sformatf("pslverr[%h]", addr), apb_rsp.pslverr, exp_err);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_check(input logic [7:0] addr, input longint exp);
        logic [31:0] rdata;
        apb_access(1'b0, addr, 32'h0, 1'b0, rdata);
        check_value($sformatf("prdata[%h]", addr), rdata, exp);
    endtask

    task automatic set_ctrl(input logic en, input int sh);
        logic [31:0] wdata;
        logic [31:0] unused;
        wdata = (32'(sh) << 4) | 32'(en);
        apb_access(1'b1, ADDR_CTRL, wdata, 1'b0, unused);
        m_enable = en;
        m_shift = sh;
        read_check(ADDR_CTRL, wdata);
    endtask

    task automatic set_weight(input int k, input int w);
        logic [7:0]  addr;
        logic [31:0] unused;
        addr = 8'(ADDR_WEIGHT0 + 4 * k);
        apb_access(1'b1, addr, 32'(w) & 32'hFF, 1'b0, unused);
        m_w[k] = w;
        read_check(addr, 32'(w) & 32'hFF);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || valid_pipe != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || valid_pipe != 0) begin
            fail_run("timeout: the FFE pipeline did not drain its expected results");
        end
    endtask

    // dense streams keep code_valid high every cycle, otherwise about one idle in four
    task automatic run_stream(input int n_cycles, input bit dense);
        logic [31:0] r;
        for (int i = 0; i < n_cycles; i++) begin
            r = $random(seed);
            @(posedge clk);
            code_valid <= dense ? 1'b1 : (r[1:0] != 2'b00);
            code <= r[15:8];
        end
        @(posedge clk);
        code_valid <= 1'b0;
        wait_drain();
    endtask

    task automatic check_count();
        logic [31:0] unused;
        read_check(ADDR_DEC_COUNT, (m_ones > 65535) ? 65535 : m_ones);
        // a nonzero write is refused and leaves the count alone
        apb_access(1'b1, ADDR_DEC_COUNT, 32'h5, 1'b1, unused);
        read_check(ADDR_DEC_COUNT, (m_ones > 65535) ? 65535 : m_ones);
        apb_access(1'b1, ADDR_DEC_COUNT, 32'h0, 1'b0, unused);
        m_ones = 0;
        read_check(ADDR_DEC_COUNT, 0);
    endtask

    // output checks and model updates on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("data_valid_o", data_valid, valid_pipe[3]);
            if (data_valid) begin
                exp_res = exp_q.pop_front();
                check_value("result_o", result, exp_res);
                check_value("data_o", data, exp_res > 0);
                if (exp_res > 0) begin
                    m_ones = m_ones + 1;
                end
            end
            accepted = code_valid && m_enable;
            if (accepted) begin
                for (int k = FFE_LENGTH - 1; k > 0; k--) begin
                    m_hist[k] = m_hist[k-1];
                end
                m_hist[0] = code;
                exp_q.push_back(model_result());
            end
            valid_pipe = {valid_pipe[2:0], accepted};
        end
    end

    initial begin
        seed = 56;
        rst_n = 1'b0;
        code = '0;
        code_valid = 1'b0;
        apb_req = '0;
        m_enable = 1'b0;
        m_shift = 0;
        m_ones = 0;
        valid_pipe = '0;
        for (int k = 0; k < FFE_LENGTH; k++) begin
            m_w[k] = 0;
            m_hist[k] = 0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);

        // reset values
        read_check(ADDR_CTRL, 0);
        for (int k = 0; k < FFE_LENGTH; k++) begin
            read_check(8'(ADDR_WEIGHT0 + 4 * k), 0);
        end
        read_check(ADDR_DEC_COUNT, 0);

        // unmapped addresses and a nonzero count write
        apb_access(1'b1, 8'h18, 32'h1, 1'b1, rd_data);
        apb_access(1'b0, 8'h02, 32'h0, 1'b1, rd_data);
        apb_access(1'b0, 8'h40, 32'h0, 1'b1, rd_data);
        apb_access(1'b1, ADDR_DEC_COUNT, 32'h5, 1'b1, rd_data);
        read_check(ADDR_CTRL, 0);

        // random configurations with sparse then back-to-back codes
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < FFE_LENGTH; k++) begin
                rd_data = $random(seed);
                set_weight(k, $signed(rd_data[7:0]));
            end
            rd_data = $random(seed);
            set_ctrl(1'b1, int'(rd_data[2:0]) + 3);
            run_stream(60, 1'b0);
            run_stream(20, 1'b1);
        end
        check_count();

        // full-scale weights with no shift drive the results into the clamp
        for (int k = 0; k < FFE_LENGTH; k++) begin
            set_weight(k, 127);
        end
        set_ctrl(1'b1, 0);
        run_stream(40, 1'b0);

        // disabled codes are dropped and the history must survive
        // shift 7 keeps full-scale sums inside the result range so every tap shows
        set_ctrl(1'b0, 7);
        run_stream(30, 1'b0);
        set_ctrl(1'b1, 7);
        run_stream(30, 1'b0);
        check_count();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rx_const_pkg.sv
rx_regs_pkg.sv
rx_apb_regs.sv
rx_sample_buffer.sv
rx_ffe.sv
rx_top.sv
tb_clk_gen.sv
tb_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the receiver testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_rx -o tb_rx_sim --Mdir obj_dir

# the simulation status is judged from the log below
./obj_dir/tb_rx_sim 2>&1 | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
